// ==== include/dbg_widths.svh ====
// ----------------------------------------------------------------------
// Width macros for the hart PC and the debug data register
// ----------------------------------------------------------------------
`ifndef DBG_WIDTHS_SVH
`define DBG_WIDTHS_SVH

`define DBG_DATA_W 32   // Debug data register
`define DBG_PC_W   16   // Program counter of the execution model

`endif

// ==== source/dbg_pkg.sv ====
// ----------------------------------------------------------------------
// Debug subsystem types: opcodes, the two views of a host command word,
// run-control, hart state, decoded command, core control and status
// ----------------------------------------------------------------------
`include "dbg_widths.svh"

package dbg_pkg;

    // Host opcodes, every other code is illegal
    typedef enum logic [3:0] {
        OP_HALT    = 4'h1,
        OP_RESUME  = 4'h2,
        OP_RUNCTRL = 4'h3,
        OP_DDR_WR  = 4'h4
    } dbg_opcode_e;

    // Debug mode entry enables
    typedef struct packed {
        logic rst_brk;
        logic sstep;
        logic brkpt;
    } dbg_dmode_en_s;

    typedef struct packed {
        logic                 irq_dsbl;
        logic                 pc_advmt_dsbl;  // Retire without moving PC
        dbg_dmode_en_s        dmode_en;
        logic [`DBG_PC_W-1:0] bp_pc;          // Breakpoint address
    } dbg_runctrl_s;

    // Opcode with raw payload
    typedef struct packed {
        logic [3:0]  opcode;
        logic [27:0] payload;
    } dbg_word_op_s;

    // Opcode with run-control layout, runctrl in the low bits
    typedef struct packed {
        logic [3:0]              opcode;
        logic [22-`DBG_PC_W:0]   rsvd;
        dbg_runctrl_s            ctrl;
    } dbg_word_rc_s;

    typedef union packed {
        dbg_word_op_s op;
        dbg_word_rc_s rc;
    } dbg_cmd_word_u;

    // Why the hart entered debug mode
    typedef struct packed {
        logic enforce;
        logic rst_brk;
        logic sstep;
        logic brkpt;
    } dbg_dmode_cause_s;

    typedef struct packed {
        logic             halted;
        logic             timeout;
        logic             except;
        logic             commit;
        dbg_dmode_cause_s dmode_cause;
    } dbg_hart_state_s;

    // Decoded command as held in the queue
    typedef struct packed {
        dbg_opcode_e            opcode;
        dbg_runctrl_s           runctrl;
        logic [`DBG_DATA_W-1:0] data;
    } dbg_cmd_s;

    // Agent to core
    typedef struct packed {
        logic                 halted;
        logic                 irq_dsbl;
        logic                 pc_advmt_dsbl;
        logic                 sstep_en;
        logic [`DBG_PC_W-1:0] bp_pc;
    } hart_ctrl_s;

    // Core to agent
    typedef struct packed {
        logic busy;
        logic instret;
        logic init_pc;  // Reset exit
        logic brkpt;    // PC hits breakpoint
        logic exc_req;
        logic commit;
    } exec_status_s;

endpackage

// ==== source/dbg_cmd_decoder.sv ====
// ----------------------------------------------------------------------
// Host command decoder, registers legal commands for the queue
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "dbg_widths.svh"

module dbg_cmd_decoder
    import dbg_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  dbg_cmd_word_u cmd_word,
    input  logic          cmd_valid,   // One-cycle strobe from host
    output dbg_cmd_s      cmd,
    output logic          push,
    output logic          bad_cmd
);

    logic     legal;
    dbg_cmd_s cmd_nxt;

    // Opcode picks which view of the word is meaningful
    always_comb begin
        legal          = 1'b1;
        cmd_nxt        = '0;
        cmd_nxt.opcode = dbg_opcode_e'(cmd_word.op.opcode);
        case (cmd_word.op.opcode)
            OP_HALT, OP_RESUME: begin
                legal = 1'b1;                          // No operands
            end
            OP_RUNCTRL: begin
                cmd_nxt.runctrl = cmd_word.rc.ctrl;    // Run-control layout
            end
            OP_DDR_WR: begin
                cmd_nxt.data = `DBG_DATA_W'(cmd_word.op.payload);  // Zero-extend
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push    <= 1'b0;
            bad_cmd <= 1'b0;
        end else begin
            push    <= cmd_valid & legal;
            bad_cmd <= cmd_valid & ~legal;   // Dropped, never queued
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (cmd_valid & legal) begin
            cmd <= cmd_nxt;
        end
    end

endmodule

// ==== source/dbg_cmd_fifo.sv ====
// ----------------------------------------------------------------------
// Circular command queue between decoder and debug agent
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module dbg_cmd_fifo
    import dbg_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  dbg_cmd_s din,
    input  logic     pop,
    output dbg_cmd_s head,
    output logic     not_empty,
    output logic     overflow   // Push lost on a full queue
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    dbg_cmd_s         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    // Wrap at FIFO_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign not_empty = |count;
    assign rd_en     = pop & not_empty;
    assign wr_en     = push & (~full | rd_en);   // Slot freed by same-cycle pop
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overflow <= push & ~wr_en;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_pop_not_empty : assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> not_empty
    ) else $error("Agent popped an empty queue");

    a_count_max : assert property (
        @(posedge clk) disable iff (!rst_n) count <= CNT_W'(FIFO_DEPTH)
    ) else $error("Queue count above depth");

endmodule

// ==== source/dbg_agent.sv ====
// ----------------------------------------------------------------------
// Debug agent: halt/run FSM, entry causes, halt timeout, cause capture,
// ack/nack per command, run-control register and debug data register
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "dbg_widths.svh"

module dbg_agent
    import dbg_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 64   // Power of two
)(
    input  logic                   clk,
    input  logic                   rst_n,
    input  dbg_cmd_s               head,
    input  logic                   cmd_req,   // Queue not empty
    output logic                   pop,
    output logic                   ack,
    output logic                   nack,
    input  exec_status_s           exec,
    output hart_ctrl_s             ctrl,
    output dbg_hart_state_s        hart_state,
    output logic                   run_start, // First cycle of run
    output logic [`DBG_DATA_W-1:0] ddr_rd
);

    localparam int TMO_W = $clog2(TIMEOUT_CYCLES);

    dbg_runctrl_s     rc_q;
    logic             halted;
    logic             run2halt;
    logic             halt2run;
    logic             enforce_dbg_mode;
    logic             enforce_run_mode;
    logic             apply_rc;
    logic             apply_ddr;
    logic             cause_rst;
    logic             cause_sstep;
    logic             cause_brk;
    logic [TMO_W-1:0] tmo_cnt;
    logic             tmo_flag;
    logic             except_q;
    logic             commit_q;
    dbg_dmode_cause_s cause_q;

    // ------------------------------------------------------------------
    // Head of queue
    // ------------------------------------------------------------------
    assign enforce_dbg_mode = cmd_req & (head.opcode == OP_HALT);
    assign enforce_run_mode = cmd_req & (head.opcode == OP_RESUME);
    assign apply_rc         = cmd_req & (head.opcode == OP_RUNCTRL);
    assign apply_ddr        = cmd_req & (head.opcode == OP_DDR_WR);

    // Entry causes from the core
    assign cause_rst   = rc_q.dmode_en.rst_brk & exec.init_pc;
    assign cause_sstep = rc_q.dmode_en.sstep   & exec.instret;
    assign cause_brk   = rc_q.dmode_en.brkpt   & exec.brkpt;

    // Timeout forces a halt even with the core busy
    assign run2halt = ~halted & (tmo_flag | (~exec.busy &
                      (cause_rst | cause_sstep | cause_brk | enforce_dbg_mode)));
    assign halt2run = halted & enforce_run_mode;

    assign ack  = halt2run | (~halted & enforce_dbg_mode & ~exec.busy & ~tmo_flag)
                | apply_rc | apply_ddr;
    assign nack = (halted & enforce_dbg_mode)              // Already halted
                | (~halted & enforce_run_mode)             // Already running
                | (~halted & enforce_dbg_mode & tmo_flag); // Core stuck busy

    // Halt and resume wait at the head until answered
    assign pop = ack | nack;

    // ------------------------------------------------------------------
    // Run state
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted    <= 1'b0;
            run_start <= 1'b0;
        end else begin
            if (run2halt) halted <= 1'b1;
            else if (halt2run) halted <= 1'b0;
            run_start <= halt2run;
        end
    end

    // Counts busy cycles of a pending halt
    assign tmo_flag = ~|tmo_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmo_cnt <= '1;
        end else if (halt2run) begin
            tmo_cnt <= '1;
        end else if (enforce_dbg_mode & exec.busy & ~halted & ~run2halt) begin
            tmo_cnt <= tmo_cnt - 1'b1;
        end
    end

    // Cause capture on entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            except_q <= 1'b0;
            commit_q <= 1'b0;
            cause_q  <= '0;
        end else if (run2halt) begin
            except_q        <= exec.exc_req;
            commit_q        <= exec.commit;
            cause_q.enforce <= enforce_dbg_mode;
            cause_q.rst_brk <= cause_rst;
            cause_q.sstep   <= cause_sstep;
            cause_q.brkpt   <= cause_brk;
        end
    end

    assign hart_state = '{halted:      halted,
                          timeout:     tmo_flag,
                          except:      except_q,
                          commit:      commit_q,
                          dmode_cause: cause_q};

    // ------------------------------------------------------------------
    // Run-control and DDR
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rc_q   <= '0;
            ddr_rd <= '0;
        end else begin
            if (apply_rc)  rc_q   <= head.runctrl;
            if (apply_ddr) ddr_rd <= head.data;
        end
    end

    assign ctrl = '{halted:        halted,
                    irq_dsbl:      rc_q.irq_dsbl,
                    pc_advmt_dsbl: rc_q.pc_advmt_dsbl,
                    sstep_en:      rc_q.dmode_en.sstep,
                    bp_pc:         rc_q.bp_pc};

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_r2h_pulse : assert property (
        @(posedge clk) disable iff (!rst_n) run2halt |=> ~run2halt
    ) else $error("run2halt longer than one cycle");

    a_h2r_pulse : assert property (
        @(posedge clk) disable iff (!rst_n) halt2run |=> ~halt2run
    ) else $error("halt2run longer than one cycle");

    a_no_retire_halted : assert property (
        @(posedge clk) disable iff (!rst_n) halted |-> ~exec.instret
    ) else $error("Instruction retired while halted");

    // Busy core without timeout stays running next cycle
    a_halt_idle : assert property (
        @(posedge clk) disable iff (!rst_n) (~halted & exec.busy & ~tmo_flag) |=> ~halted
    ) else $error("Halt entered with core busy");

endmodule

// ==== source/hart_exec.sv ====
// ----------------------------------------------------------------------
// Execution model standing in for the core: PC, stalls, retire,
// breakpoint match and reset-exit pulse
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "dbg_widths.svh"

module hart_exec
    import dbg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  hart_ctrl_s           ctrl,
    input  logic                 stall,    // Holds the core busy
    output exec_status_s         status,
    output logic [`DBG_PC_W-1:0] pc
);

    logic retire;
    logic init_done;
    logic init_pc;

    // One instruction per cycle when running and not stalled
    assign retire = ~ctrl.halted & ~stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (retire & ~ctrl.pc_advmt_dsbl) begin
            pc <= pc + 1'b1;
        end
    end

    // Reset exit, high for the first cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_done <= 1'b0;
            init_pc   <= 1'b0;
        end else begin
            init_done <= 1'b1;
            init_pc   <= ~init_done;
        end
    end

    assign status = '{busy:    stall,
                      instret: retire,
                      init_pc: init_pc,
                      brkpt:   (pc == ctrl.bp_pc),
                      exc_req: 1'b0,          // Model raises no exceptions
                      commit:  retire};

endmodule

// ==== source/dbg_subsys_top.sv ====
// ----------------------------------------------------------------------
// Debug subsystem top: decoder, command queue, agent, execution model
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "dbg_widths.svh"

module dbg_subsys_top
    import dbg_pkg::*;
#(
    parameter int FIFO_DEPTH     = 4,
    parameter int TIMEOUT_CYCLES = 64
)(
    input  logic                   clk,
    input  logic                   rst_n,       // Whole subsystem
    input  logic                   hart_rst_n,  // Core only, run-control kept
    input  dbg_cmd_word_u          cmd_word,
    input  logic                   cmd_valid,
    input  logic                   stall,
    output logic                   halted,
    output logic [`DBG_PC_W-1:0]   pc,
    output dbg_hart_state_s        hart_state,
    output logic                   cmd_ack,
    output logic                   cmd_nack,
    output logic                   bad_cmd,
    output logic                   overflow,
    output logic                   run_start,
    output logic [`DBG_DATA_W-1:0] ddr_rd
);

    dbg_cmd_s     dec_cmd;
    dbg_cmd_s     head;
    logic         push;
    logic         pop;
    logic         not_empty;
    hart_ctrl_s   ctrl;
    exec_status_s status;
    logic         core_rst_n;

    assign core_rst_n = rst_n & hart_rst_n;   // Either reset clears the core
    assign halted     = ctrl.halted;

    dbg_cmd_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_word  (cmd_word),
        .cmd_valid (cmd_valid),
        .cmd       (dec_cmd),
        .push      (push),
        .bad_cmd   (bad_cmd)
    );

    dbg_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .din       (dec_cmd),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    dbg_agent #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_agent (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .cmd_req    (not_empty),
        .pop        (pop),
        .ack        (cmd_ack),
        .nack       (cmd_nack),
        .exec       (status),
        .ctrl       (ctrl),
        .hart_state (hart_state),
        .run_start  (run_start),
        .ddr_rd     (ddr_rd)
    );

    hart_exec u_hart (
        .clk    (clk),
        .rst_n  (core_rst_n),
        .ctrl   (ctrl),
        .stall  (stall),
        .status (status),
        .pc     (pc)
    );

endmodule

// ==== bench/tb_dbg_subsys.sv ====
// ----------------------------------------------------------------------
// Testbench for the debug subsystem: replays the command trace,
// waits for ack/nack/bad_cmd or a halted change, checks the results
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`include "dbg_widths.svh"

module tb_dbg_subsys
    import dbg_pkg::*;
;

    localparam int CLK_PERIOD     = 4;
    localparam int FIFO_DEPTH     = 4;
    localparam int TIMEOUT_CYCLES = 16;     // Short halt timeout keeps the run brief

    // One trace line
    typedef struct packed {
        logic [7:0]             id;
        logic [1:0]             kind;       // 1 command strobe, 2 core reset pulse
        logic [31:0]            word;
        logic                   stall;
        logic [15:0]            max_wait;
        logic                   ack;
        logic                   nack;
        logic                   bad;
        logic                   halted;
        logic                   tmo;
        logic [3:0]             cause;      // enforce, rst_brk, sstep, brkpt
        logic [`DBG_DATA_W-1:0] ddr;
    } trace_line_s;

    logic                   clk;
    logic                   rst_n;
    logic                   hart_rst_n;
    dbg_cmd_word_u          cmd_word;
    logic                   cmd_valid;
    logic                   stall;
    logic                   halted;
    logic [`DBG_PC_W-1:0]   pc;
    dbg_hart_state_s        hart_state;
    logic                   cmd_ack;
    logic                   cmd_nack;
    logic                   bad_cmd;
    logic                   overflow;
    logic                   run_start;
    logic [`DBG_DATA_W-1:0] ddr_rd;

    trace_line_s trace_q[$];
    int          max_wait_all;
    logic        loaded;
    int          err_count;
    int          test_errs;
    int          test_lines;
    int          n_tests;
    int          cur_id;
    int          cur_line;
    logic        last_exp_halted;   // Halted state the previous line ended in

    // Core model state at the last sample
    logic [`DBG_PC_W-1:0] pc_prev;
    logic                 halted_prev;
    dbg_runctrl_s         rc_now;   // Run-control the core sees
    dbg_runctrl_s         rc_next;
    logic                 rc_pend;

    dbg_subsys_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .hart_rst_n (hart_rst_n),
        .cmd_word   (cmd_word),
        .cmd_valid  (cmd_valid),
        .stall      (stall),
        .halted     (halted),
        .pc         (pc),
        .hart_state (hart_state),
        .cmd_ack    (cmd_ack),
        .cmd_nack   (cmd_nack),
        .bad_cmd    (bad_cmd),
        .overflow   (overflow),
        .run_start  (run_start),
        .ddr_rd     (ddr_rd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic note_error();
        err_count++;
        test_errs++;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: test %0d line %0d %s is %0h, expected %0h",
                     $time, cur_id, cur_line, name, got, exp);
            note_error();
        end
    endtask

    // Comment lines start with #
    task automatic read_trace(output logic ok);
        int          fd;
        int          n;
        string       text;
        int          f_id, f_kind, f_stall, f_wait;
        int          f_ack, f_nack, f_bad, f_halt, f_tmo;
        logic [31:0] f_word, f_cause, f_ddr;
        trace_line_s e;
        fd = $fopen("bench/dbg_trace.txt", "r");
        max_wait_all = 0;
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (n > 0 && text.substr(0, 0) != "#") begin
                    n = $sscanf(text, "%d %d %h %d %d %d %d %d %d %d %h %h",
                                f_id, f_kind, f_word, f_stall, f_wait, f_ack, f_nack,
                                f_bad, f_halt, f_tmo, f_cause, f_ddr);
                    if (n == 12) begin
                        e = '{id: 8'(f_id), kind: 2'(f_kind), word: f_word,
                              stall: 1'(f_stall), max_wait: 16'(f_wait),
                              ack: 1'(f_ack), nack: 1'(f_nack), bad: 1'(f_bad),
                              halted: 1'(f_halt), tmo: 1'(f_tmo),
                              cause: 4'(f_cause), ddr: f_ddr};
                        trace_q.push_back(e);
                        if (f_wait > max_wait_all) max_wait_all = f_wait;
                    end
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && (trace_q.size() > 0);
    endtask

    // PC, breakpoint entry and cause capture over the cycle since the last sample
    task automatic track_core(input logic core_rst, input logic rc_ack,
                              input dbg_runctrl_s rc_new);
        logic [`DBG_PC_W-1:0] pc_exp;
        pc_exp = pc_prev;
        if (core_rst) begin
            pc_exp = '0;                          // Core held in reset
        end else if (!halted_prev && !stall && !rc_now.pc_advmt_dsbl) begin
            pc_exp = pc_prev + 1'b1;              // One retire per running cycle
        end
        compare_field("pc", 32'(pc), 32'(pc_exp));
        if (!core_rst && !halted_prev && !stall && rc_now.dmode_en.brkpt &&
            (pc_prev == rc_now.bp_pc) && !halted) begin
            $display("ERR %0t: test %0d line %0d no halt on breakpoint at pc %0h",
                     $time, cur_id, cur_line, pc_prev);
            note_error();
        end
        // Entry captures commit of that cycle, model never raises exceptions
        if (halted && !halted_prev) begin
            compare_field("commit", 32'(hart_state.commit), 32'(!stall));
            compare_field("except", 32'(hart_state.except), 32'h0);
        end
        if (rc_pend) rc_now = rc_next;            // Taken by the agent last cycle
        rc_pend     = rc_ack;
        rc_next     = rc_new;
        pc_prev     = pc;
        halted_prev = halted;
    endtask

    // Drive one line, wait for the response, then check it
    task automatic run_line(input trace_line_s e);
        int            cycles;
        int            runs;
        logic          seen_ack;
        logic          seen_nack;
        logic          seen_bad;
        logic          seen_ovf;
        logic          done;
        logic          is_rc;
        dbg_cmd_word_u w;
        cycles    = 0;
        runs      = 0;
        seen_ack  = 1'b0;
        seen_nack = 1'b0;
        seen_bad  = 1'b0;
        seen_ovf  = 1'b0;
        done      = 1'b0;
        w         = e.word;
        is_rc     = (e.kind == 2'd1) && (w.op.opcode == OP_RUNCTRL);
        stall     = e.stall;
        if (e.kind == 2'd1) begin
            cmd_word  = e.word;
            cmd_valid = 1'b1;
        end else if (e.kind == 2'd2) begin
            hart_rst_n = 1'b0;                    // Core only, agent keeps state
        end
        while (!done && cycles < int'(e.max_wait)) begin
            @(negedge clk);
            seen_ack  |= cmd_ack;                 // Sample first, then drive
            seen_nack |= cmd_nack;
            seen_bad  |= bad_cmd;
            seen_ovf  |= overflow;
            if (run_start) runs++;
            track_core(~hart_rst_n, is_rc & cmd_ack, w.rc.ctrl);
            cmd_valid  = 1'b0;
            hart_rst_n = 1'b1;
            cycles++;
            if (((e.kind != 2'd1) || seen_ack || seen_nack || seen_bad) &&
                (halted == e.halted)) done = 1'b1;
        end
        if (!done) begin
            $display("Test %0d line %0d: no response from the DUT within %0d cycles",
                     cur_id, cur_line, e.max_wait);
            note_error();
        end
        @(negedge clk);                           // Registered results settle
        seen_ack  |= cmd_ack;
        seen_nack |= cmd_nack;
        seen_bad  |= bad_cmd;
        seen_ovf  |= overflow;
        if (run_start) runs++;
        track_core(1'b0, is_rc & cmd_ack, w.rc.ctrl);
        compare_field("ack", 32'(seen_ack), 32'(e.ack));
        compare_field("nack", 32'(seen_nack), 32'(e.nack));
        compare_field("bad_cmd", 32'(seen_bad), 32'(e.bad));
        compare_field("overflow", 32'(seen_ovf), 32'h0);
        compare_field("halted", 32'(halted), 32'(e.halted));
        compare_field("hart_state.halted", 32'(hart_state.halted), 32'(e.halted));
        compare_field("timeout", 32'(hart_state.timeout), 32'(e.tmo));
        compare_field("cause", 32'(hart_state.dmode_cause), 32'(e.cause));
        compare_field("ddr_rd", ddr_rd, e.ddr);
        // One run_start pulse per resume out of halt
        compare_field("run_start", runs, 32'(last_exp_halted & ~e.halted));
        last_exp_halted = e.halted;
        test_lines++;
    endtask

    task automatic report_test();
        $display("test %0d finished: %0d lines, %0d errors", cur_id, test_lines, test_errs);
        n_tests++;
        test_errs  = 0;
        test_lines = 0;
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin : main
        logic ok;
        rst_n           = 1'b0;
        hart_rst_n      = 1'b1;
        cmd_word        = '0;
        cmd_valid       = 1'b0;
        stall           = 1'b0;
        loaded          = 1'b0;
        err_count       = 0;
        test_errs       = 0;
        test_lines      = 0;
        n_tests         = 0;
        cur_id          = 0;
        cur_line        = 0;
        last_exp_halted = 1'b0;
        pc_prev         = '0;
        halted_prev     = 1'b0;
        rc_now          = '0;
        rc_next         = '0;
        rc_pend         = 1'b0;
        read_trace(ok);
        if (!ok) begin
            $display("Trace file bench/dbg_trace.txt is missing or holds no lines");
            $display("TEST FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            track_core(1'b0, 1'b0, '0);           // First running cycle after reset
            foreach (trace_q[i]) begin
                if (i > 0 && int'(trace_q[i].id) != cur_id) report_test();
                cur_id   = int'(trace_q[i].id);
                cur_line = i + 1;
                run_line(trace_q[i]);
            end
            report_test();
            $display("Summary: %0d tests, %0d trace lines, %0d errors",
                     n_tests, trace_q.size(), err_count);
            if (err_count == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    // Limit from trace length, longest wait and the halt timeout
    initial begin : watchdog
        longint limit;
        wait (loaded);
        limit = longint'(trace_q.size()) * (max_wait_all + 4) + 4 * TIMEOUT_CYCLES + 16;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, trace did not finish", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== bench/dbg_trace.txt ====
# id kind word stall max_wait ack nack bad halted timeout cause ddr_rd
# kind 1 = command strobe, 2 = core reset pulse; cause = enforce rst_brk sstep brkpt
1 1 30040000 0 8   1 0 0 0 0 0 00000000
1 2 00000000 0 8   0 0 0 1 0 4 00000000
1 1 30000000 0 8   1 0 0 1 0 4 00000000
1 1 20000000 0 8   1 0 0 0 0 4 00000000
2 1 10000000 0 8   1 0 0 1 0 8 00000000
2 1 10000000 0 8   0 1 0 1 0 8 00000000
2 1 20000000 0 8   1 0 0 0 0 8 00000000
2 1 20000000 0 8   0 1 0 0 0 8 00000000
3 1 30010080 0 160 1 0 0 1 0 1 00000000
3 1 30000000 0 8   1 0 0 1 0 1 00000000
3 1 20000000 0 8   1 0 0 0 0 1 00000000
4 1 10000000 1 24  0 1 0 1 1 8 00000000
4 1 20000000 0 8   1 0 0 0 0 8 00000000
5 1 4abc1234 0 8   1 0 0 0 0 8 0abc1234
5 1 400000ff 0 8   1 0 0 0 0 8 000000ff
6 1 f0000000 0 8   0 0 1 0 0 8 000000ff
6 1 10000000 0 8   1 0 0 1 0 8 000000ff
6 1 01234567 0 8   0 0 1 1 0 8 000000ff
6 1 20000000 0 8   1 0 0 0 0 8 000000ff

// ==== tb.f ====
+incdir+include
source/dbg_pkg.sv
source/dbg_cmd_decoder.sv
source/dbg_cmd_fifo.sv
source/dbg_agent.sv
source/hart_exec.sv
source/dbg_subsys_top.sv
bench/tb_dbg_subsys.sv

// ==== Bender.yml ====
package:
  name: dbg_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/dbg_pkg.sv
      - source/dbg_cmd_decoder.sv
      - source/dbg_cmd_fifo.sv
      - source/dbg_agent.sv
      - source/hart_exec.sv
      - source/dbg_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_dbg_subsys.sv
